//--- Makefile
# Verilator build and run of the enemy layer testbench
# every variable below can be overridden on the command line

TOP             ?= tb_enemy_layer
FILELIST        ?= enemy_layer.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
OBJ_DIR         ?= obj_dir

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

//--- enemy_ctl.sv
// ----------------------------------------------------------------------
// moves the enemy row once per frame, left and right only
// the move happens at the start of the first blank line
// the row plus STEP must fit inside H_ACTIVE, or the bounce misbehaves
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module enemy_ctl import enemy_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 480,
  parameter int N        = 8,
  parameter int EN_W     = 32,
  parameter int EN_GAP   = 64,
  parameter int STEP     = 4
) (
  input  wire logic       pclk,
  input  wire logic       rst_i,
  input  wire logic       enable_i,  // low freezes the row
  vga_if.snk              bus,       // only the counters are used
  output logic [CNT_W-1:0] xpos_o,   // left edge of enemy 0
  output dir_t            dir_o
);

  // full row width, left edge of first to right edge of last
  localparam int ROW_W = (N - 1) * EN_GAP + EN_W;

  localparam logic [CNT_W-1:0] STEP_C   = CNT_W'(STEP);
  localparam logic [CNT_W-1:0] V_BLANK0 = CNT_W'(V_ACTIVE); // first blank line

  ctl_state_t       state, state_nxt;
  logic [CNT_W-1:0] xpos_q, xpos_nxt;
  dir_t             dir_q, dir_nxt;
  logic             frame_edge;
  logic             hit_right;
  logic             hit_left;

  // one cycle per frame, at the first blank line
  assign frame_edge = (bus.vcount == V_BLANK0) && (bus.hcount == '0);

  // bounce tests, done in int so nothing wraps
  assign hit_right = (int'(xpos_q) + STEP + ROW_W) > H_ACTIVE;
  assign hit_left  = (xpos_q < STEP_C);

  always_comb begin
    state_nxt = state;
    xpos_nxt  = xpos_q;
    dir_nxt   = dir_q;
    case (state)
      ST_WAIT_FRAME: begin
        if (frame_edge) begin
          state_nxt = ST_MOVE;
        end
      end
      ST_MOVE: begin
        state_nxt = ST_WAIT_FRAME; // single step per frame
        if (enable_i) begin
          if (dir_q == DIR_RIGHT) begin
            if (hit_right) begin
              dir_nxt  = DIR_LEFT;       // reached right edge, turn
              xpos_nxt = xpos_q - STEP_C;
            end else begin
              xpos_nxt = xpos_q + STEP_C;
            end
          end else begin
            if (hit_left) begin
              dir_nxt  = DIR_RIGHT;      // reached left edge
              xpos_nxt = xpos_q + STEP_C;
            end else begin
              xpos_nxt = xpos_q - STEP_C;
            end
          end
        end
      end
      default: state_nxt = ST_WAIT_FRAME;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst_i) begin
      state  <= ST_WAIT_FRAME;
      xpos_q <= '0;
      dir_q  <= DIR_RIGHT;
    end else begin
      state  <= state_nxt;
      xpos_q <= xpos_nxt;
      dir_q  <= dir_nxt;
    end
  end

  assign xpos_o = xpos_q;
  assign dir_o  = dir_q;

endmodule

`default_nettype wire

//--- enemy_draw.sv
// ----------------------------------------------------------------------
// paints the enemy row over the background, one pclk of latency
// all timing fields leave delayed by one cycle, colour is 0 in blanking
// the leading column of each enemy (by direction) is drawn full white
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module enemy_draw import enemy_pkg::*; #(
  parameter int N      = 8,
  parameter int EN_W   = 32,
  parameter int EN_H   = 24,
  parameter int EN_GAP = 64,
  parameter int EN_Y   = 64
) (
  input  wire logic             pclk,
  input  wire logic             rst_i,
  input  wire logic             enable_i,
  input  wire logic [CNT_W-1:0] xpos_i,   // left edge of enemy 0
  input  wire dir_t             dir_i,
  vga_if.snk                    in_bus,
  vga_if.src                    out_bus
);

  // highlight on the leading column
  localparam rgb_t LEAD_COLOR = '{r: 4'hf, g: 4'hf, b: 4'hf};

  logic in_row;  // current line crosses the row
  logic hit;     // pixel inside some enemy
  logic lead;    // pixel on a leading column
  logic blank;
  rgb_t rgb_nxt;

  assign blank  = in_bus.hblnk | in_bus.vblnk;
  assign in_row = (int'(in_bus.vcount) >= EN_Y) && (int'(in_bus.vcount) < EN_Y + EN_H);

  // N rectangle compares, one per enemy
  always_comb begin : hit_calc
    int hx;
    int x_left;
    hit  = 1'b0;
    lead = 1'b0;
    hx   = int'(in_bus.hcount);
    for (int k = 0; k < N; k++) begin
      x_left = int'(xpos_i) + k * EN_GAP;
      if ((hx >= x_left) && (hx < x_left + EN_W)) begin
        hit = 1'b1;
        if (dir_i == DIR_RIGHT) begin
          lead = lead | (hx == x_left + EN_W - 1); // right column
        end else begin
          lead = lead | (hx == x_left);            // left column
        end
      end
    end
  end

  // colour select, blanking wins over everything
  always_comb begin
    if (blank) begin
      rgb_nxt = '0;
    end else if (enable_i && in_row && hit) begin
      rgb_nxt = lead ? LEAD_COLOR : ENEMY_COLOR;
    end else begin
      rgb_nxt = in_bus.rgb;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst_i) begin
      out_bus.hcount <= '0;
      out_bus.vcount <= '0;
      out_bus.hsync  <= 1'b1;
      out_bus.vsync  <= 1'b1;
      out_bus.hblnk  <= 1'b0;
      out_bus.vblnk  <= 1'b0;
      out_bus.rgb    <= '0;
    end else begin
      out_bus.hcount <= in_bus.hcount; // plain one-cycle delay
      out_bus.vcount <= in_bus.vcount;
      out_bus.hsync  <= in_bus.hsync;
      out_bus.vsync  <= in_bus.vsync;
      out_bus.hblnk  <= in_bus.hblnk;
      out_bus.vblnk  <= in_bus.vblnk;
      out_bus.rgb    <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

//--- enemy_layer.f
enemy_pkg.sv
vga_if.sv
vga_timing.sv
enemy_ctl.sv
enemy_draw.sv
enemy_layer.sv
enemy_layer_assert.sv
tb_enemy_layer.sv

//--- enemy_layer.sv
// ----------------------------------------------------------------------
// enemy layer top: timing, row controller and draw stage
// every output lags the internal timing by one pclk
// no stall possible, the stream runs freely from reset
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module enemy_layer import enemy_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33,
  parameter int N        = 8,   // enemies in the row
  parameter int EN_W     = 32,
  parameter int EN_H     = 24,
  parameter int EN_GAP   = 64,  // left edge to left edge
  parameter int EN_Y     = 64,  // top line of the row
  parameter int STEP     = 4    // pixels per frame
) (
  input  wire logic             pclk,
  input  wire logic             rst_i,
  input  wire logic             enable_i,
  input  wire rgb_t             rgb_i,    // background
  output logic [CNT_W-1:0]      hcount_o,
  output logic [CNT_W-1:0]      vcount_o,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  hblnk_o,
  output logic                  vblnk_o,
  output rgb_t                  rgb_o
);

  logic [CNT_W-1:0] xpos;  // row position from the controller
  dir_t             dir;

  vga_if tim_bus ();  // raw timing plus background
  vga_if out_bus ();  // after the overlay

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) i_timing (
    .pclk  (pclk),
    .rst_i (rst_i),
    .rgb_i (rgb_i),
    .bus   (tim_bus.src)
  );

  enemy_ctl #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .N(N),
    .EN_W(EN_W), .EN_GAP(EN_GAP), .STEP(STEP)
  ) i_ctl (
    .pclk     (pclk),
    .rst_i    (rst_i),
    .enable_i (enable_i),
    .bus      (tim_bus.snk),
    .xpos_o   (xpos),
    .dir_o    (dir)
  );

  enemy_draw #(
    .N(N), .EN_W(EN_W), .EN_H(EN_H), .EN_GAP(EN_GAP), .EN_Y(EN_Y)
  ) i_draw (
    .pclk     (pclk),
    .rst_i    (rst_i),
    .enable_i (enable_i),
    .xpos_i   (xpos),
    .dir_i    (dir),
    .in_bus   (tim_bus.snk),
    .out_bus  (out_bus.src)
  );

  // unpack the drawn stream onto the pins
  assign hcount_o = out_bus.hcount;
  assign vcount_o = out_bus.vcount;
  assign hsync_o  = out_bus.hsync;
  assign vsync_o  = out_bus.vsync;
  assign hblnk_o  = out_bus.hblnk;
  assign vblnk_o  = out_bus.vblnk;
  assign rgb_o    = out_bus.rgb;

endmodule

`default_nettype wire

//--- enemy_layer_assert.sv
// ----------------------------------------------------------------------
// concurrent checks on the enemy layer pins and the row position
// bound into every enemy_layer, parameters taken from the bound scope
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module enemy_layer_assert import enemy_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int N        = 8,
  parameter int EN_W     = 32,
  parameter int EN_GAP   = 64
) (
  input wire logic             pclk,
  input wire logic             rst_i,
  input wire logic             hsync_i,
  input wire logic             hblnk_i,
  input wire logic             vblnk_i,
  input wire rgb_t             rgb_i,
  input wire logic [CNT_W-1:0] xpos_i   // left edge of enemy 0
);

  localparam int ROW_W = (N - 1) * EN_GAP + EN_W; // whole row width

  // hsync pulse lives inside horizontal blanking
  sync_in_blank: assert property (@(posedge pclk) disable iff (rst_i) !hsync_i |-> hblnk_i)
    else $error("hsync low while hblnk is low");

  // nothing drawn in the porches
  dark_in_blank: assert property (@(posedge pclk) disable iff (rst_i)
    (hblnk_i || vblnk_i) |-> (rgb_i == '0))
    else $error("non-zero colour during blanking");

  row_on_screen: assert property (@(posedge pclk) disable iff (rst_i)
    (int'(xpos_i) + ROW_W) <= H_ACTIVE)
    else $error("enemy row extends past the visible width");

endmodule

bind enemy_layer enemy_layer_assert #(
  .H_ACTIVE(H_ACTIVE), .N(N), .EN_W(EN_W), .EN_GAP(EN_GAP)
) i_assert (
  .pclk    (pclk),
  .rst_i   (rst_i),
  .hsync_i (hsync_o),
  .hblnk_i (hblnk_o),
  .vblnk_i (vblnk_o),
  .rgb_i   (rgb_o),
  .xpos_i  (xpos)
);

`default_nettype wire

//--- enemy_pkg.sv
// ----------------------------------------------------------------------
// shared types for the enemy layer of the VGA game
// counters are CNT_W wide, enough for screens up to 2047 pixels
// colours are 4 bits per channel, packed r, g, b from msb down
// ----------------------------------------------------------------------
`default_nettype none

package enemy_pkg;

  // pixel and line counter width
  localparam int CNT_W = 11;

  // 12-bit colour, red in the top nibble
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // body colour of an enemy, a dull green
  localparam rgb_t ENEMY_COLOR = '{r: 4'h2, g: 4'hd, b: 4'h3};

  // horizontal direction of the whole row
  typedef enum logic {
    DIR_RIGHT = 1'b0,
    DIR_LEFT  = 1'b1
  } dir_t;

  // enemy controller FSM
  typedef enum logic {
    ST_WAIT_FRAME = 1'b0, // idle until first blank line
    ST_MOVE       = 1'b1  // one step, then back to waiting
  } ctl_state_t;

endpackage

`default_nettype wire

//--- tb_enemy_layer.sv
// ----------------------------------------------------------------------
// directed testbench for the enemy layer on a 40 x 20 total screen
// rgb_o lags the driven background by two pclk, a short history tracks it
// enable only changes at frame start, the row never reaches line 0
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_enemy_layer import enemy_pkg::*; ();

  localparam int H_ACTIVE = 32;
  localparam int H_FP     = 2;
  localparam int H_SYNC   = 4;
  localparam int H_BP     = 2;
  localparam int V_ACTIVE = 16;
  localparam int V_FP     = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 1;
  localparam int N        = 2;
  localparam int EN_W     = 4;
  localparam int EN_H     = 3;
  localparam int EN_GAP   = 8;
  localparam int EN_Y     = 4;
  localparam int STEP     = 3;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int ROW_W    = (N - 1) * EN_GAP + EN_W;
  localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
  localparam int PERIOD   = 40;
  localparam int TEST_FRAMES = 24;  // reset, 2 timing, 1 paint, 16 motion, 4 disable
  localparam int WATCHDOG_NS = TEST_FRAMES * FRAME_CYC * PERIOD * 3 / 2;
  localparam rgb_t WHITE  = '{r: 4'hf, g: 4'hf, b: 4'hf};

  logic             pclk;
  logic             rst_i;
  logic             enable_i;
  rgb_t             rgb_i;
  logic [CNT_W-1:0] hcount_o;
  logic [CNT_W-1:0] vcount_o;
  logic             hsync_o;
  logic             vsync_o;
  logic             hblnk_o;
  logic             vblnk_o;
  rgb_t             rgb_o;

  int          mdl_x;     // reference row position
  dir_t        mdl_dir;
  logic        en_want;   // enable level for the current frame
  logic        rand_bg;   // random or black background
  logic [16:0] lfsr_q;
  rgb_t        bg_now;    // driven this cycle
  rgb_t        bg_d1;
  rgb_t        bg_d2;     // what rgb_o shows now
  int          h_exp;     // reference counters
  int          v_exp;

  enemy_layer #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .N(N), .EN_W(EN_W), .EN_H(EN_H), .EN_GAP(EN_GAP), .EN_Y(EN_Y), .STEP(STEP)
  ) i_dut (
    .pclk(pclk), .rst_i(rst_i), .enable_i(enable_i), .rgb_i(rgb_i),
    .hcount_o(hcount_o), .vcount_o(vcount_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
    .hblnk_o(hblnk_o), .vblnk_o(vblnk_o), .rgb_o(rgb_o)
  );

  initial pclk = 1'b0;
  always #(PERIOD / 2) pclk = ~pclk;

  // x^17 + x^14 + 1, new bit enters at the bottom
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic random_rgb(output rgb_t c);
    logic [11:0] bits;
    for (int i = 0; i < 12; i++) begin
      lfsr_q  = lfsr_next(lfsr_q);  // one step per bit
      bits[i] = lfsr_q[0];
    end
    c = bits;
  endtask

  // bounce rule applied at each frame boundary
  task automatic model_move();
    if (mdl_dir == DIR_RIGHT) begin
      if (mdl_x + STEP + ROW_W > H_ACTIVE) begin
        mdl_dir = DIR_LEFT;
        mdl_x   = mdl_x - STEP;
      end else begin
        mdl_x = mdl_x + STEP;
      end
    end else if (mdl_x < STEP) begin
      mdl_dir = DIR_RIGHT;
      mdl_x   = mdl_x + STEP;
    end else begin
      mdl_x = mdl_x - STEP;
    end
  endtask

  function automatic rgb_t expected_rgb(input int hc, input int vc, input rgb_t bg);
    rgb_t c;
    int   left;
    c = bg;
    for (int k = 0; k < N; k++) begin
      left = mdl_x + k * EN_GAP;
      if (en_want && vc >= EN_Y && vc < EN_Y + EN_H && hc >= left && hc < left + EN_W) begin
        c = ENEMY_COLOR;
        if ((mdl_dir == DIR_RIGHT && hc == left + EN_W - 1) ||
            (mdl_dir == DIR_LEFT && hc == left)) begin
          c = WHITE;  // leading column
        end
      end
    end
    if (hc >= H_ACTIVE || vc >= V_ACTIVE) begin
      c = '0;
    end
    return c;
  endfunction

  task automatic stop_on_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_dir(input string name, input dir_t exp, input dir_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
      stop_on_failure();
    end
  endtask

  // one pclk: drive on the rising edge, sample on the falling edge
  task automatic clock_pixel(input logic rst);
    @(posedge pclk);
    bg_d2 = bg_d1;
    bg_d1 = bg_now;
    if (rand_bg) begin
      random_rgb(bg_now);
    end else begin
      bg_now = '0;
    end
    rst_i    <= rst;
    enable_i <= en_want;
    rgb_i    <= bg_now;
    @(negedge pclk);
    if (!rst_i && hcount_o == '0 && int'(vcount_o) == V_ACTIVE && en_want) begin
      model_move();  // first blank line seen at the pins
    end
  endtask

  task automatic verify_pixel(input string name);
    logic hs_exp;
    logic vs_exp;
    hs_exp = !(h_exp >= H_ACTIVE + H_FP && h_exp < H_ACTIVE + H_FP + H_SYNC);
    vs_exp = !(v_exp >= V_ACTIVE + V_FP && v_exp < V_ACTIVE + V_FP + V_SYNC);
    check_count({name, " hcount"}, CNT_W'(h_exp), hcount_o);
    check_count({name, " vcount"}, CNT_W'(v_exp), vcount_o);
    check_bit({name, " hblnk"}, h_exp >= H_ACTIVE, hblnk_o);
    check_bit({name, " vblnk"}, v_exp >= V_ACTIVE, vblnk_o);
    check_bit({name, " hsync"}, hs_exp, hsync_o);
    check_bit({name, " vsync"}, vs_exp, vsync_o);
    check_rgb({name, " rgb"}, expected_rgb(h_exp, v_exp, bg_d2), rgb_o);
    if (h_exp == H_TOTAL - 1) begin
      h_exp = 0;
      v_exp = (v_exp == V_TOTAL - 1) ? 0 : v_exp + 1;  // wrap to next frame
    end else begin
      h_exp = h_exp + 1;
    end
  endtask

  // starts and ends on pixel (0,0), returns leftmost enemy pixel of line EN_Y
  task automatic run_frame(input string name, output int found_x);
    found_x = -1;
    repeat (FRAME_CYC) begin
      verify_pixel(name);
      if (found_x < 0 && int'(vcount_o) == EN_Y && !hblnk_o &&
          (rgb_o == ENEMY_COLOR || rgb_o == WHITE)) begin
        found_x = int'(hcount_o);
      end
      clock_pixel(1'b0);
    end
  endtask

  task automatic reset_state();
    repeat (16) begin
      clock_pixel(1'b1);
      check_bit("reset hsync", 1'b1, hsync_o);
      check_bit("reset vsync", 1'b1, vsync_o);
      check_rgb("reset rgb", '0, rgb_o);
    end
    clock_pixel(1'b0);  // release, outputs still in reset
    check_bit("release hsync", 1'b1, hsync_o);
    check_bit("release vsync", 1'b1, vsync_o);
    check_rgb("release rgb", '0, rgb_o);
    clock_pixel(1'b0);
    check_count("first hcount", '0, hcount_o);
    check_count("first vcount", '0, vcount_o);
  endtask

  task automatic frame_timing();
    int fx;
    run_frame("timing frame 1", fx);
    run_frame("timing frame 2", fx);
  endtask

  task automatic enemy_painting();
    int fx;
    rand_bg = 1'b1;
    run_frame("painting", fx);
    rand_bg = 1'b0;
  endtask

  // 16 frames cover a right and a left bounce from the current position
  task automatic motion_bounce();
    int   prev_x;
    int   cur_x;
    int   frame_x;
    int   delta;
    dir_t start_dir;
    dir_t seen_dir;
    dir_t last_dir;
    logic turn_right_edge;
    logic turn_left_edge;
    turn_right_edge = 1'b0;
    turn_left_edge  = 1'b0;
    last_dir        = DIR_RIGHT;
    prev_x          = 0;
    for (int i = 0; i < 16; i++) begin
      frame_x   = mdl_x;
      start_dir = mdl_dir;  // direction of the move just made
      run_frame("motion", cur_x);
      check_count("motion xpos", CNT_W'(frame_x), CNT_W'(cur_x));
      if (i > 0) begin
        delta    = cur_x - prev_x;
        seen_dir = (delta > 0) ? DIR_RIGHT : DIR_LEFT;
        check_count("motion step", CNT_W'(STEP), CNT_W'(delta < 0 ? -delta : delta));
        check_dir("motion dir", start_dir, seen_dir);
        if (i > 1 && seen_dir != last_dir) begin
          if (seen_dir == DIR_LEFT) begin
            turn_right_edge = 1'b1;
          end else begin
            turn_left_edge = 1'b1;
          end
        end
        last_dir = seen_dir;
      end
      prev_x = cur_x;
    end
    check_bit("motion right bounce", 1'b1, turn_right_edge);
    check_bit("motion left bounce", 1'b1, turn_left_edge);
  endtask

  task automatic disable_hold();
    int held_x;
    int frame_x;
    int fx;
    held_x  = mdl_x;
    en_want = 1'b0;
    rand_bg = 1'b1;  // every visible pixel must be the background
    run_frame("disabled", fx);
    run_frame("disabled", fx);
    en_want = 1'b1;
    rand_bg = 1'b0;
    run_frame("resume hold", fx);
    check_count("resume held xpos", CNT_W'(held_x), CNT_W'(fx));
    frame_x = mdl_x;
    run_frame("resume move", fx);
    check_count("resume xpos", CNT_W'(frame_x), CNT_W'(fx));
    check_count("resume step", CNT_W'(STEP), CNT_W'(fx > held_x ? fx - held_x : held_x - fx));
  endtask

  initial begin
    rst_i    <= 1'b1;
    enable_i <= 1'b1;
    rgb_i    <= '0;
    en_want  = 1'b1;
    rand_bg  = 1'b0;
    lfsr_q   = 17'd80935;
    bg_now   = '0;
    bg_d1    = '0;
    bg_d2    = '0;
    mdl_x    = 0;
    mdl_dir  = DIR_RIGHT;
    h_exp    = 0;
    v_exp    = 0;
    reset_state();
    frame_timing();
    enemy_painting();
    motion_bounce();
    disable_hold();
    $display("Finished with no errors");
    $finish;
  end

  // bound on total run time, 1.5 times the frames used
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    stop_on_failure();
  end

endmodule

`default_nettype wire

//--- vga_if.sv
// ----------------------------------------------------------------------
// one VGA pixel stream: counters, syncs, blanking and colour
// syncs are active low, blank flags active high
// every field is a plain level, valid on each pclk cycle
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface vga_if import enemy_pkg::*; ();

  logic [CNT_W-1:0] hcount; // pixel within the line
  logic [CNT_W-1:0] vcount; // line within the frame
  logic             hsync;  // active low
  logic             vsync;  // active low
  logic             hblnk;
  logic             vblnk;
  rgb_t             rgb;

  // driving side of the stream
  modport src (
    output hcount, vcount,
    output hsync, vsync,
    output hblnk, vblnk,
    output rgb
  );

  // receiving side
  modport snk (
    input hcount, vcount,
    input hsync, vsync,
    input hblnk, vblnk,
    input rgb
  );

endinterface

`default_nettype wire

//--- vga_timing.sv
// ----------------------------------------------------------------------
// VGA frame timing from porch and sync parameters
// counters start at 0 after reset, syncs come up inactive (high)
// sync and blanking are registered in step with the counters
// background colour is registered alongside, so it has one cycle delay
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module vga_timing import enemy_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33
) (
  input  wire logic pclk,
  input  wire logic rst_i,
  input  wire rgb_t rgb_i,   // background pixel
  vga_if.src        bus
);

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

  // counter limits, sized to the counters
  localparam logic [CNT_W-1:0] H_LAST   = CNT_W'(H_TOTAL - 1);
  localparam logic [CNT_W-1:0] V_LAST   = CNT_W'(V_TOTAL - 1);
  localparam logic [CNT_W-1:0] H_VIS    = CNT_W'(H_ACTIVE);
  localparam logic [CNT_W-1:0] V_VIS    = CNT_W'(V_ACTIVE);
  localparam logic [CNT_W-1:0] HS_START = CNT_W'(H_ACTIVE + H_FP);
  localparam logic [CNT_W-1:0] HS_END   = CNT_W'(H_ACTIVE + H_FP + H_SYNC);
  localparam logic [CNT_W-1:0] VS_START = CNT_W'(V_ACTIVE + V_FP);
  localparam logic [CNT_W-1:0] VS_END   = CNT_W'(V_ACTIVE + V_FP + V_SYNC);

  logic [CNT_W-1:0] h_nxt;
  logic [CNT_W-1:0] v_nxt;
  logic             h_wrap;

  assign h_wrap = (bus.hcount == H_LAST);

  // next counter values, flags below are decoded from these
  always_comb begin
    h_nxt = h_wrap ? '0 : bus.hcount + 1'b1;
    v_nxt = bus.vcount;
    if (h_wrap) begin
      v_nxt = (bus.vcount == V_LAST) ? '0 : bus.vcount + 1'b1; // new line
    end
  end

  always_ff @(posedge pclk) begin
    if (rst_i) begin
      bus.hcount <= '0;
      bus.vcount <= '0;
      bus.hsync  <= 1'b1;   // inactive
      bus.vsync  <= 1'b1;
      bus.hblnk  <= 1'b0;   // pixel 0 is visible
      bus.vblnk  <= 1'b0;
      bus.rgb    <= '0;
    end else begin
      bus.hcount <= h_nxt;
      bus.vcount <= v_nxt;
      bus.hblnk  <= (h_nxt >= H_VIS);
      bus.vblnk  <= (v_nxt >= V_VIS);
      // sync pulses sit between front and back porch
      bus.hsync  <= !((h_nxt >= HS_START) && (h_nxt < HS_END));
      bus.vsync  <= !((v_nxt >= VS_START) && (v_nxt < VS_END));
      bus.rgb    <= rgb_i; // background travels with its counters
    end
  end

endmodule

`default_nettype wire
